// ==== hw/op_lut_config.svh ====
// queue count, port count, route table depth and ttl limit macros for the lookup stage
`ifndef OP_LUT_CONFIG_SVH
`define OP_LUT_CONFIG_SVH

// ====================
// output queues
// ====================

// one-hot queue width, mac queues on even bits and cpu queues on odd bits
`define OP_LUT_NUM_QUEUES 8
`define OP_LUT_NUM_PORTS 4         // input ports
`define OP_LUT_CPU_QUEUE_OFFSET 1  // cpu queue sits one above its mac queue

// ====================
// route table
// ====================

`define OP_LUT_LPM_DEPTH 8
`define OP_LUT_LPM_DEPTH_BITS 3

// ====================
// header checks
// ====================

`define OP_LUT_MIN_TTL 2  // smallest ttl still forwarded

`endif

// ==== hw/op_lut_pkg.sv ====
// ipv4 header, route entry, check and route result, decision types and the action enum
`default_nettype none

`include "op_lut_config.svh"

package op_lut_pkg;

   typedef logic [`OP_LUT_NUM_QUEUES-1:0] oq_t;               // one-hot output queue
   typedef logic [$clog2(`OP_LUT_NUM_PORTS)-1:0] port_t;

   // 20 byte header, first byte on the wire in the msbs
   typedef struct packed {
      logic [7:0]  ver_ihl;
      logic [7:0]  tos;
      logic [15:0] total_len;
      logic [15:0] ident;
      logic [15:0] flags_frag;
      logic [7:0]  ttl;
      logic [7:0]  proto;
      logic [15:0] checksum;
      logic [31:0] src_ip;
      logic [31:0] dst_ip;
   } ipv4_hdr_t;

   typedef struct packed {
      port_t     in_port;
      ipv4_hdr_t ip;
   } pkt_hdr_t;

   typedef struct packed {
      logic [31:0] prefix;
      logic [31:0] mask;
      oq_t         queue;  // zero queue marks the entry unused
   } route_entry_t;

   typedef struct packed {
      logic        checksum_good;
      logic        options_or_bad_ver;
      logic        ttl_good;
      logic [7:0]  new_ttl;
      logic [15:0] new_checksum;  // valid for the decremented ttl
   } hdr_check_t;

   typedef struct packed {
      logic hit;
      oq_t  queue;
   } route_result_t;

   typedef enum logic [2:0] {
      act_forward,
      act_drop_checksum,
      act_cpu_options,
      act_cpu_ttl,
      act_cpu_lpm_miss
   } op_action_e;

   typedef struct packed {
      op_action_e action;
      oq_t        queue;
      pkt_hdr_t   hdr;
   } lookup_decision_t;

endpackage

`default_nettype wire

// ==== hw/ip_hdr_check.sv ====
// ip_hdr_check module: checksum, version/ihl and ttl checks with ttl and checksum rewrite
`timescale 1ns/100ps
`default_nettype none

`include "op_lut_config.svh"

module ip_hdr_check (
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire                    in_vld,
   input  op_lut_pkg::pkt_hdr_t   in_hdr,
   output logic                   chk_vld,
   output op_lut_pkg::pkt_hdr_t   chk_hdr,
   output op_lut_pkg::hdr_check_t chk
);

   import op_lut_pkg::*;

   // ones' complement sum over the ten halfwords, carries folded back in
   function automatic logic [15:0] ones_sum(input ipv4_hdr_t h);
      logic [159:0] bits;
      logic [19:0]  acc;
      bits = h;
      acc = '0;
      for (int i = 0; i < 10; i++) begin
         acc = acc + 20'(bits[i*16 +: 16]);
      end
      acc = 20'(acc[15:0]) + 20'(acc[19:16]);
      acc = 20'(acc[15:0]) + 20'(acc[19:16]);  // second fold catches the last carry
      return acc[15:0];
   endfunction

   ipv4_hdr_t   fwd_ip;  // header as sent when forwarded, checksum field cleared
   logic [15:0] rx_sum;
   hdr_check_t  chk_d;

   // ====================
   // checks
   // ====================

   always_comb begin
      fwd_ip = in_hdr.ip;
      fwd_ip.ttl = in_hdr.ip.ttl - 8'd1;
      fwd_ip.checksum = '0;
      rx_sum = ones_sum(in_hdr.ip);

      chk_d.checksum_good = (rx_sum == 16'hffff);
      chk_d.options_or_bad_ver = (in_hdr.ip.ver_ihl != 8'h45);  // v4 with ihl 5 only
      chk_d.ttl_good = (in_hdr.ip.ttl >= 8'(`OP_LUT_MIN_TTL));
      chk_d.new_ttl = fwd_ip.ttl;
      chk_d.new_checksum = ~ones_sum(fwd_ip);
   end

   // ====================
   // result register
   // ====================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         chk_vld <= 1'b0;
      end else begin
         chk_vld <= in_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (in_vld) begin
         chk_hdr <= in_hdr;  // travels alongside the check result
         chk <= chk_d;
      end
   end

   a_chk_vld_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(chk_vld));

endmodule

`default_nettype wire

// ==== hw/route_lpm.sv ====
// route_lpm module: route table registers, write port and prioritized prefix match
`timescale 1ns/100ps
`default_nettype none

`include "op_lut_config.svh"

module route_lpm (
   input  wire                              clk,
   input  wire                              arst_n,
   input  wire                              in_vld,
   input  wire  [31:0]                      dst_ip,
   input  wire                              lpm_wr,
   input  wire  [`OP_LUT_LPM_DEPTH_BITS-1:0] lpm_wr_addr,
   input  op_lut_pkg::route_entry_t         lpm_wr_entry,
   output logic                             route_vld,
   output op_lut_pkg::route_result_t        route
);

   import op_lut_pkg::*;

   // even bits of the queue vector are the mac queues
   localparam oq_t mac_queues = {(`OP_LUT_NUM_QUEUES/2){2'b01}};

   route_entry_t                  rt_entry [`OP_LUT_LPM_DEPTH];
   logic [`OP_LUT_LPM_DEPTH-1:0]  rt_valid;
   logic [`OP_LUT_LPM_DEPTH-1:0]  match;
   route_result_t                 route_d;

   // ====================
   // table write
   // ====================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rt_valid <= '0;
         for (int i = 0; i < `OP_LUT_LPM_DEPTH; i++) begin
            rt_entry[i] <= '0;
         end
      end else if (lpm_wr) begin
         rt_entry[lpm_wr_addr] <= lpm_wr_entry;
         rt_valid[lpm_wr_addr] <= (lpm_wr_entry.queue != '0);  // zero queue clears the entry
      end
   end

   // ====================
   // parallel match
   // ====================

   always_comb begin
      for (int i = 0; i < `OP_LUT_LPM_DEPTH; i++) begin
         match[i] = rt_valid[i] &&
                    ((dst_ip & rt_entry[i].mask) == (rt_entry[i].prefix & rt_entry[i].mask));
      end
   end

   // walk down from the top so the lowest index hit is the last one kept
   always_comb begin
      route_d = '0;
      for (int i = `OP_LUT_LPM_DEPTH - 1; i >= 0; i--) begin
         if (match[i]) begin
            route_d.hit = 1'b1;
            route_d.queue = rt_entry[i].queue;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         route_vld <= 1'b0;
      end else begin
         route_vld <= in_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (in_vld) begin
         route <= route_d;
      end
   end

   // entries in use must point at exactly one mac queue
   a_wr_queue_mac: assert property (@(posedge clk) disable iff (!arst_n)
      lpm_wr && (lpm_wr_entry.queue != '0) |->
         $onehot(lpm_wr_entry.queue) && ((lpm_wr_entry.queue & ~mac_queues) == '0));

endmodule

`default_nettype wire

// ==== hw/forward_decide.sv ====
// forward_decide module: action priority, output queue select and header rewrite
`timescale 1ns/100ps
`default_nettype none

`include "op_lut_config.svh"

module forward_decide (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          chk_vld,
   input  op_lut_pkg::pkt_hdr_t         chk_hdr,
   input  op_lut_pkg::hdr_check_t       chk,
   input  op_lut_pkg::route_result_t    route,
   output logic                         out_vld,
   output op_lut_pkg::lookup_decision_t out_decision
);

   import op_lut_pkg::*;

   oq_t              cpu_queue;
   lookup_decision_t decision_d;

   // ====================
   // decision
   // ====================

   always_comb begin
      // cpu queue of the port the packet came in on
      cpu_queue = oq_t'(1) << ({chk_hdr.in_port, 1'b0} + `OP_LUT_CPU_QUEUE_OFFSET);

      decision_d.hdr = chk_hdr;
      decision_d.queue = cpu_queue;
      if (!chk.checksum_good) begin
         decision_d.action = act_drop_checksum;
         decision_d.queue = '0;
      end else if (chk.options_or_bad_ver) begin
         decision_d.action = act_cpu_options;
      end else if (!chk.ttl_good) begin
         decision_d.action = act_cpu_ttl;
      end else if (!route.hit) begin
         decision_d.action = act_cpu_lpm_miss;
      end else begin
         decision_d.action = act_forward;
         decision_d.queue = route.queue;
         decision_d.hdr.ip.ttl = chk.new_ttl;            // only forwarded headers change
         decision_d.hdr.ip.checksum = chk.new_checksum;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_vld <= 1'b0;
      end else begin
         out_vld <= chk_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (chk_vld) begin
         out_decision <= decision_d;
      end
   end

   a_fwd_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      out_vld && (out_decision.action == act_forward) |-> $onehot(out_decision.queue));

   a_drop_no_queue: assert property (@(posedge clk) disable iff (!arst_n)
      out_vld && (out_decision.action == act_drop_checksum) |-> (out_decision.queue == '0));

endmodule

`default_nettype wire

// ==== hw/output_port_lookup.sv ====
// output_port_lookup module: header check and route lookup side by side, then the decision
`timescale 1ns/100ps
`default_nettype none

`include "op_lut_config.svh"

module output_port_lookup (
   input  wire                              clk,
   input  wire                              arst_n,
   input  wire                              in_vld,
   input  op_lut_pkg::pkt_hdr_t             in_hdr,
   input  wire                              lpm_wr,
   input  wire  [`OP_LUT_LPM_DEPTH_BITS-1:0] lpm_wr_addr,
   input  op_lut_pkg::route_entry_t         lpm_wr_entry,
   output logic                             out_vld,
   output op_lut_pkg::lookup_decision_t     out_decision
);

   import op_lut_pkg::*;

   logic          chk_vld;
   pkt_hdr_t      chk_hdr;
   hdr_check_t    chk;
   logic          route_vld;  // only watched, decision runs on chk_vld
   route_result_t route;

   ip_hdr_check ip_hdr_check (
      .clk     (clk),
      .arst_n  (arst_n),
      .in_vld  (in_vld),
      .in_hdr  (in_hdr),
      .chk_vld (chk_vld),
      .chk_hdr (chk_hdr),   // header copy aligned with the check
      .chk     (chk)
   );

   route_lpm route_lpm (
      .clk          (clk),
      .arst_n       (arst_n),
      .in_vld       (in_vld),
      .dst_ip       (in_hdr.ip.dst_ip),
      .lpm_wr       (lpm_wr),
      .lpm_wr_addr  (lpm_wr_addr),
      .lpm_wr_entry (lpm_wr_entry),
      .route_vld    (route_vld),
      .route        (route)
   );

   forward_decide forward_decide (
      .clk          (clk),
      .arst_n       (arst_n),
      .chk_vld      (chk_vld),
      .chk_hdr      (chk_hdr),
      .chk          (chk),
      .route        (route),
      .out_vld      (out_vld),
      .out_decision (out_decision)
   );

   // both halves run in lockstep
   a_vld_aligned: assert property (@(posedge clk) disable iff (!arst_n)
      route_vld == chk_vld);

endmodule

`default_nettype wire

// ==== sim/op_lut_checker.sv ====
// op_lut_checker module: expected decision queue, output compare and latency check
`timescale 1ns/100ps
`default_nettype none

module op_lut_checker (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          exp_vld,
   input  op_lut_pkg::lookup_decision_t exp_decision,
   input  wire                          out_vld,
   input  op_lut_pkg::lookup_decision_t out_decision,
   output int                           mismatch_errs,
   output int                           order_errs,
   output int                           pending
);

   import op_lut_pkg::*;

   localparam int latency = 2;  // input strobe to out_vld

   lookup_decision_t exp_q [$];
   int               stamp_q [$];  // cycle each decision was queued
   int               cyc;
   int               born;
   lookup_decision_t want;

   // ====================
   // compare on every output
   // ====================

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_q.delete();
         stamp_q.delete();
         cyc = 0;
      end else begin
         cyc = cyc + 1;
         if (exp_vld) begin
            exp_q.push_back(exp_decision);
            stamp_q.push_back(cyc);
         end
         if (out_vld && exp_q.size() == 0) begin
            order_errs++;
            $display("output at %0t ns arrived with no decision waiting for it", $time);
         end else if (out_vld) begin
            want = exp_q.pop_front();
            born = stamp_q.pop_front();
            if (cyc - born != latency) begin
               mismatch_errs++;
               $display("[FAIL] %0t ns: latency %0d cycles", $time, cyc - born);
            end
            if (out_decision.action !== want.action) begin
               mismatch_errs++;
               $display("[FAIL] %0t ns: action %s, expected %s", $time,
                        out_decision.action.name(), want.action.name());
            end
            if (out_decision.queue !== want.queue) begin
               mismatch_errs++;
               $display("[FAIL] %0t ns: queue %b, expected %b", $time,
                        out_decision.queue, want.queue);
            end
            if (out_decision.hdr !== want.hdr) begin
               mismatch_errs++;
               $display("[FAIL] %0t ns: header %h, expected %h", $time,
                        out_decision.hdr, want.hdr);
            end
         end
         // oldest decision is overdue
         if (exp_q.size() != 0 && cyc - stamp_q[0] >= latency) begin
            order_errs++;
            $display("no output came for the header sent in cycle %0d", stamp_q[0]);
            void'(exp_q.pop_front());
            void'(stamp_q.pop_front());
         end
         pending = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_output_port_lookup.sv ====
// tb_output_port_lookup module: clock, reset, route table load, random headers, model and report
`timescale 1ns/100ps
`default_nettype none

`include "op_lut_config.svh"

module tb_output_port_lookup;

   import op_lut_pkg::*;

   typedef logic [`OP_LUT_LPM_DEPTH_BITS-1:0] rt_addr_t;

   localparam int num_pkts    = 400;
   localparam int num_routes  = 6;
   localparam int cycle_limit = 1000;  // 400 headers plus table load, reset and margin

   // nested prefixes, longest first, queues on mac bits only
   localparam route_entry_t routes [num_routes] = '{
      '{32'h0a01_0200, 32'hffff_ff00, 8'h01},  // /24
      '{32'h0a01_0000, 32'hffff_f000, 8'h04},  // /20
      '{32'h0a01_0000, 32'hffff_0000, 8'h10},
      '{32'hc0a0_0000, 32'hfff0_0000, 8'h40},
      '{32'h0a00_0000, 32'hff00_0000, 8'h04},
      '{32'h0000_0000, 32'h0000_0000, 8'h01}   // default route
   };

   logic             clk;
   logic             arst_n;
   logic             in_vld;
   pkt_hdr_t         in_hdr;
   logic             lpm_wr;
   rt_addr_t         lpm_wr_addr;
   route_entry_t     lpm_wr_entry;
   logic             out_vld;
   lookup_decision_t out_decision;
   logic             exp_vld;
   lookup_decision_t exp_decision;
   int               mismatch_errs;
   int               order_errs;
   int               pending;
   int               cycles;
   integer           seed;
   route_entry_t     rt_model [`OP_LUT_LPM_DEPTH];  // table as the model sees it

   output_port_lookup uut (.*);
   op_lut_checker check_out (.*);

   always #10 clk = ~clk;

   // ====================
   // reference model
   // ====================

   function automatic logic [15:0] hdr_sum(input ipv4_hdr_t ip);
      logic [159:0] raw;
      logic [31:0]  total;
      raw = ip;
      total = 32'h0;
      for (int k = 0; k < 10; k++) begin
         total = total + {16'h0, raw[k*16 +: 16]};
      end
      while (total[31:16] != 16'h0) begin
         total = {16'h0, total[15:0]} + {16'h0, total[31:16]};  // end-around carry
      end
      return total[15:0];
   endfunction

   function automatic lookup_decision_t model_decision(input pkt_hdr_t h);
      lookup_decision_t d;
      logic             hit;
      oq_t              hit_q;
      hit = 1'b0;
      hit_q = '0;
      for (int i = 0; i < `OP_LUT_LPM_DEPTH; i++) begin
         if (!hit && rt_model[i].queue != '0 &&
             (h.ip.dst_ip & rt_model[i].mask) == (rt_model[i].prefix & rt_model[i].mask)) begin
            hit = 1'b1;
            hit_q = rt_model[i].queue;
         end
      end
      d.hdr = h;
      d.queue = oq_t'(1) << (2 * h.in_port + 1);  // cpu queue of the input port
      if (hdr_sum(h.ip) != 16'hffff) begin
         d.action = act_drop_checksum;
         d.queue = '0;
      end else if (h.ip.ver_ihl[7:4] != 4'd4 || h.ip.ver_ihl[3:0] != 4'd5) begin
         d.action = act_cpu_options;
      end else if (h.ip.ttl < 8'(`OP_LUT_MIN_TTL)) begin
         d.action = act_cpu_ttl;
      end else if (!hit) begin
         d.action = act_cpu_lpm_miss;
      end else begin
         d.action = act_forward;
         d.queue = hit_q;
         d.hdr.ip.ttl = h.ip.ttl - 8'd1;
         d.hdr.ip.checksum = 16'h0;
         d.hdr.ip.checksum = ~hdr_sum(d.hdr.ip);
      end
      return d;
   endfunction

   // ====================
   // stimulus
   // ====================

   task automatic make_header(output pkt_hdr_t h);
      int           kind;
      route_entry_t r;
      kind = {$random(seed)} % 10;
      r = routes[{$random(seed)} % num_routes];
      h.in_port = port_t'($random(seed));
      h.ip = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      h.ip.ver_ihl = 8'h45;
      h.ip.ttl = 8'({$random(seed)} % 6);
      if ({$random(seed)} % 4 != 0) begin
         h.ip.dst_ip = (r.prefix & r.mask) | ($random(seed) & ~r.mask);
      end
      if (kind == 1) begin
         case ({$random(seed)} % 3)
            0:       h.ip.ver_ihl = 8'h46;  // ihl 6
            1:       h.ip.ver_ihl = 8'h47;
            default: h.ip.ver_ihl = 8'h65;  // version 6
         endcase
      end
      h.ip.checksum = 16'h0;
      h.ip.checksum = ~hdr_sum(h.ip);
      if (kind == 0) begin
         h.ip.checksum = h.ip.checksum ^ (16'($random(seed)) | 16'h0001);
      end
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, %0d decisions still outstanding", cycles, pending);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      pkt_hdr_t h;
      seed = 24;
      clk = 1'b0;
      arst_n = 1'b0;
      in_vld = 1'b0;
      in_hdr = '0;
      lpm_wr = 1'b0;
      lpm_wr_addr = '0;
      lpm_wr_entry = '0;
      exp_vld = 1'b0;
      exp_decision = '0;
      for (int i = 0; i < `OP_LUT_LPM_DEPTH; i++) begin
         rt_model[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      for (int i = 0; i < num_routes; i++) begin
         @(negedge clk);
         lpm_wr = 1'b1;
         lpm_wr_addr = rt_addr_t'(i);
         lpm_wr_entry = routes[i];
         rt_model[i] = routes[i];
      end

      for (int n = 0; n < num_pkts; n++) begin
         @(negedge clk);
         lpm_wr = 1'b0;
         if ({$random(seed)} % 8 == 0) begin  // idle cycle now and then
            in_vld = 1'b0;
            exp_vld = 1'b0;
            @(negedge clk);
         end
         make_header(h);
         in_hdr = h;
         in_vld = 1'b1;
         exp_decision = model_decision(h);
         exp_vld = 1'b1;
         if (n == num_pkts / 2) begin
            // default route goes away, this header still sees it
            lpm_wr = 1'b1;
            lpm_wr_addr = rt_addr_t'(num_routes - 1);
            lpm_wr_entry = '0;
            rt_model[num_routes - 1] = '0;
         end
      end
      @(negedge clk);
      in_vld = 1'b0;
      exp_vld = 1'b0;
      lpm_wr = 1'b0;
      while (pending != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);  // room for a stray extra output

      $display("errors: %0d mismatched, %0d missing or unexpected outputs",
               mismatch_errs, order_errs);
      if (mismatch_errs == 0 && order_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== output_port_lookup.f ====
+incdir+hw
hw/op_lut_pkg.sv
hw/ip_hdr_check.sv
hw/route_lpm.sv
hw/forward_decide.sv
hw/output_port_lookup.sv
sim/op_lut_checker.sv
sim/tb_output_port_lookup.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the output port lookup testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_output_port_lookup \
   -f output_port_lookup.f -o tb_output_port_lookup \
   && ./obj_dir/tb_output_port_lookup | tee /dev/stderr \
      | grep -q '\*\*\* TEST PASSED \*\*\*' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
